/* include/ec_defines.svh */
`ifndef EC_DEFINES_SVH
`define EC_DEFINES_SVH

// ----------------------------------------------------------------------
// Datapath widths
// ----------------------------------------------------------------------

// Range and probabilities
`define EC_RANGE_WIDTH  16

// Low register of the coder
`define EC_LOW_WIDTH    24

// Symbol index width, the symbol count has one bit more
`define EC_SYMBOL_WIDTH 4

// Signed bit counter
`define EC_CNT_WIDTH    5

// ----------------------------------------------------------------------
// Probability scaling
// ----------------------------------------------------------------------
`define EC_PROB_SHIFT   6
`define EC_MIN_PROB     4

// ----------------------------------------------------------------------
// Coder state after reset
// ----------------------------------------------------------------------
`define EC_RANGE_INIT   32768
`define EC_CNT_INIT     (-9)

`endif

/* src/ec_pkg.sv */
`include "ec_defines.svh"

package ec_pkg;

  // Range value or scaled probability
  typedef logic [`EC_RANGE_WIDTH-1:0]      range_t;
  typedef logic [`EC_LOW_WIDTH-1:0]        low_t;
  typedef logic [`EC_SYMBOL_WIDTH-1:0]     symbol_t;
  typedef logic [`EC_SYMBOL_WIDTH:0]       nsyms_t;
  typedef logic signed [`EC_CNT_WIDTH-1:0] cnt_t;

  // Bit 0 set when word_1 is written, bit 1 set when word_2 is written
  typedef logic [1:0]                      emit_flag_t;

  // Only the top byte of the range enters the product
  localparam int range_top_shift = `EC_RANGE_WIDTH - 8;
  localparam int prod_width      = 2 * `EC_RANGE_WIDTH - 8 - `EC_PROB_SHIFT;

  // Scaled split point of the range for one probability value
  function automatic range_t scale_prob(range_t r, range_t f);
    logic [prod_width-1:0] r_top;
    logic [prod_width-1:0] f_scaled;
    logic [prod_width-1:0] prod;
    r_top    = prod_width'(r >> range_top_shift);
    f_scaled = prod_width'(f >> `EC_PROB_SHIFT);
    prod     = r_top * f_scaled;
    // Halved product
    return prod[`EC_RANGE_WIDTH:1];
  endfunction

endpackage

/* src/cdf_interval.sv */
`timescale 1ns/1ns
`include "ec_defines.svh"

module cdf_interval (
  input  logic            general_clk,
  input  logic            reset,
  input  logic            symbol_strobe,
  input  logic            bool_mode,
  input  ec_pkg::range_t  cur_range,
  input  ec_pkg::range_t  fl,
  input  ec_pkg::range_t  fh,
  input  ec_pkg::symbol_t symbol,
  input  ec_pkg::nsyms_t  nsyms,
  output ec_pkg::range_t  low_incr,
  output ec_pkg::range_t  next_range,
  output logic            cdf_valid
);

  localparam ec_pkg::range_t min_prob = ec_pkg::range_t'(`EC_MIN_PROB);

  logic           fire;
  ec_pkg::nsyms_t remaining_u;
  ec_pkg::nsyms_t remaining_v;
  ec_pkg::range_t offset_u;
  ec_pkg::range_t offset_v;
  ec_pkg::range_t bound_u;
  ec_pkg::range_t bound_v;

  // Multi-symbol coding only
  assign fire = symbol_strobe & ~bool_mode;

  // --------------------------------------------------------------------
  // Minimum probability offsets
  // --------------------------------------------------------------------

  // Symbols left above each bound
  assign remaining_u = nsyms - ec_pkg::nsyms_t'(symbol);
  assign remaining_v = remaining_u - ec_pkg::nsyms_t'(1);

  // Each remaining symbol reserves the minimum probability
  assign offset_u = min_prob * ec_pkg::range_t'(remaining_u);
  assign offset_v = min_prob * ec_pkg::range_t'(remaining_v);

  // --------------------------------------------------------------------
  // Scaled cumulative bounds
  // --------------------------------------------------------------------

  // Symbol 0 takes the whole range as its upper bound
  assign bound_u = (symbol == '0) ? cur_range
                                  : ec_pkg::scale_prob(cur_range, fl) + offset_u;

  assign bound_v = ec_pkg::scale_prob(cur_range, fh) + offset_v;

  // --------------------------------------------------------------------
  // Result registers
  // --------------------------------------------------------------------

  always_ff @(posedge general_clk) begin
    if (reset) begin
      cdf_valid <= 1'b0;
    end else begin
      cdf_valid <= fire;
    end
  end

  // Interval result of the current symbol
  always_ff @(posedge general_clk) begin
    if (fire) begin
      // Low moves up past the part of the range above the symbol
      low_incr   <= cur_range - bound_u;
      next_range <= bound_u - bound_v;
    end
  end

endmodule

/* src/bool_interval.sv */
`timescale 1ns/1ns
`include "ec_defines.svh"

module bool_interval (
  input  logic           general_clk,
  input  logic           reset,
  input  logic           symbol_strobe,
  input  logic           bool_mode,
  input  ec_pkg::range_t cur_range,
  input  ec_pkg::range_t fh,
  input  logic           bit_value,
  output ec_pkg::range_t low_incr,
  output ec_pkg::range_t next_range,
  output logic           bool_valid
);

  localparam ec_pkg::range_t min_prob = ec_pkg::range_t'(`EC_MIN_PROB);

  logic           fire;
  ec_pkg::range_t split;
  ec_pkg::range_t incr_d;
  ec_pkg::range_t range_d;

  assign fire = symbol_strobe & bool_mode;

  // Single split point of the range
  assign split = ec_pkg::scale_prob(cur_range, fh) + min_prob;

  // --------------------------------------------------------------------
  // Part selection by the coded bit
  // --------------------------------------------------------------------
  always_comb begin
    if (bit_value) begin
      // Lower part kept while low skips the upper part
      incr_d  = cur_range - split;
      range_d = split;
    end else begin
      incr_d  = '0;
      range_d = cur_range - split;
    end
  end

  always_ff @(posedge general_clk) begin
    if (reset) begin
      bool_valid <= 1'b0;
    end else begin
      bool_valid <= fire;
    end
  end

  // Interval result of the current bool
  always_ff @(posedge general_clk) begin
    if (fire) begin
      low_incr   <= incr_d;
      next_range <= range_d;
    end
  end

endmodule

/* src/renormalizer.sv */
`timescale 1ns/1ns
`include "ec_defines.svh"

module renormalizer (
  input  logic               general_clk,
  input  logic               reset,
  input  logic               cdf_valid,
  input  ec_pkg::range_t     cdf_low_incr,
  input  ec_pkg::range_t     cdf_range,
  input  logic               bool_valid,
  input  ec_pkg::range_t     bool_low_incr,
  input  ec_pkg::range_t     bool_range,
  output ec_pkg::range_t     cur_range,
  output ec_pkg::low_t       low,
  output ec_pkg::cnt_t       cnt,
  output ec_pkg::range_t     word_1,
  output ec_pkg::range_t     word_2,
  output ec_pkg::emit_flag_t emit_flag,
  output logic               result_valid
);

  localparam int shift_width = $clog2(`EC_RANGE_WIDTH + 1);
  // One extra bit keeps the carry of low plus increment
  localparam int work_width  = `EC_LOW_WIDTH + 1;
  localparam int sum_width   = `EC_CNT_WIDTH + 2;

  typedef logic [work_width-1:0]       work_t;
  typedef logic signed [sum_width-1:0] sum_t;

  // Leading zeros of a range value, where zero gives the full width
  function automatic logic [shift_width-1:0] count_lz(ec_pkg::range_t value);
    logic [shift_width-1:0] zeros;
    zeros = shift_width'(`EC_RANGE_WIDTH);
    for (int i = 0; i < `EC_RANGE_WIDTH; i++) begin
      if (value[i]) begin
        zeros = shift_width'(`EC_RANGE_WIDTH - 1 - i);
      end
    end
    return zeros;
  endfunction

  // Keeps the bits of low below a position
  function automatic work_t low_mask(sum_t position);
    return (work_t'(1) << position) - work_t'(1);
  endfunction

  logic                   in_valid;
  ec_pkg::range_t         sel_incr;
  ec_pkg::range_t         sel_range;
  logic [shift_width-1:0] d;
  sum_t                   d_ext;
  sum_t                   s_sum;
  logic                   emit;
  logic                   emit_two;
  sum_t                   c;
  work_t                  work;
  ec_pkg::range_t         first_word;
  ec_pkg::range_t         last_word;
  ec_pkg::cnt_t           cnt_next;
  ec_pkg::low_t           low_next;
  ec_pkg::range_t         range_next;

  // --------------------------------------------------------------------
  // Active interval result
  // --------------------------------------------------------------------
  assign in_valid  = cdf_valid | bool_valid;
  assign sel_incr  = cdf_valid ? cdf_low_incr : bool_low_incr;
  assign sel_range = cdf_valid ? cdf_range : bool_range;

  // Renormalization shift
  assign d     = count_lz(sel_range);
  assign d_ext = sum_t'(d);

  assign s_sum    = sum_t'(cnt) + d_ext;
  assign emit     = (s_sum >= 0);
  // Enough bits for two bytes
  assign emit_two = (s_sum >= 8);

  // --------------------------------------------------------------------
  // Word emission and renormalization
  // --------------------------------------------------------------------
  always_comb begin
    work       = work_t'(low) + work_t'(sel_incr);
    c          = sum_t'(cnt) + sum_t'(`EC_RANGE_WIDTH);
    first_word = '0;
    last_word  = '0;
    cnt_next   = ec_pkg::cnt_t'(s_sum);
    if (emit) begin
      if (emit_two) begin
        first_word = ec_pkg::range_t'(work >> c);
        work       = work & low_mask(c);
        c          = c - sum_t'(8);
      end
      // Word keeps its carry bit above the byte
      last_word = ec_pkg::range_t'(work >> c);
      work      = work & low_mask(c);
      cnt_next  = ec_pkg::cnt_t'(c + d_ext - sum_t'(24));
    end
    low_next   = ec_pkg::low_t'(work << d);
    range_next = sel_range << d;
  end

  // --------------------------------------------------------------------
  // Coder state
  // --------------------------------------------------------------------
  always_ff @(posedge general_clk) begin
    if (reset) begin
      cur_range    <= ec_pkg::range_t'(`EC_RANGE_INIT);
      low          <= '0;
      cnt          <= ec_pkg::cnt_t'(`EC_CNT_INIT);
      result_valid <= 1'b0;
    end else begin
      result_valid <= in_valid;
      if (in_valid) begin
        cur_range <= range_next;
        low       <= low_next;
        cnt       <= cnt_next;
      end
    end
  end

  // Words and flag hold on results without emission
  always_ff @(posedge general_clk) begin
    if (reset) begin
      word_1    <= '0;
      word_2    <= '0;
      emit_flag <= '0;
    end else if (in_valid && emit) begin
      emit_flag <= {emit_two, 1'b1};
      word_1    <= emit_two ? first_word : last_word;
      if (emit_two) begin
        word_2 <= last_word;
      end
    end
  end

endmodule

/* src/range_encoder_top.sv */
`timescale 1ns/1ns

module range_encoder_top (
  input  logic               general_clk,
  input  logic               reset,
  input  logic               symbol_strobe,
  input  logic               bool_mode,
  input  ec_pkg::range_t     fl,
  input  ec_pkg::range_t     fh,
  input  ec_pkg::symbol_t    symbol,
  input  ec_pkg::nsyms_t     nsyms,
  output ec_pkg::range_t     range,
  output ec_pkg::low_t       low,
  output ec_pkg::cnt_t       cnt,
  output ec_pkg::range_t     word_1,
  output ec_pkg::range_t     word_2,
  output ec_pkg::emit_flag_t emit_flag,
  output logic               result_valid
);

  ec_pkg::range_t cdf_low_incr;
  ec_pkg::range_t cdf_range;
  logic           cdf_valid;
  ec_pkg::range_t bool_low_incr;
  ec_pkg::range_t bool_range;
  logic           bool_valid;

  // --------------------------------------------------------------------
  // Interval units fed back with the current range
  // --------------------------------------------------------------------
  cdf_interval i_cdf_interval (
    .general_clk   (general_clk),
    .reset         (reset),
    .symbol_strobe (symbol_strobe),
    .bool_mode     (bool_mode),
    .cur_range     (range),
    .fl            (fl),
    .fh            (fh),
    .symbol        (symbol),
    .nsyms         (nsyms),
    .low_incr      (cdf_low_incr),
    .next_range    (cdf_range),
    .cdf_valid     (cdf_valid)
  );

  // Coded bit is symbol bit 0
  bool_interval i_bool_interval (
    .general_clk   (general_clk),
    .reset         (reset),
    .symbol_strobe (symbol_strobe),
    .bool_mode     (bool_mode),
    .cur_range     (range),
    .fh            (fh),
    .bit_value     (symbol[0]),
    .low_incr      (bool_low_incr),
    .next_range    (bool_range),
    .bool_valid    (bool_valid)
  );

  // Coder state and word output
  renormalizer i_renormalizer (
    .general_clk   (general_clk),
    .reset         (reset),
    .cdf_valid     (cdf_valid),
    .cdf_low_incr  (cdf_low_incr),
    .cdf_range     (cdf_range),
    .bool_valid    (bool_valid),
    .bool_low_incr (bool_low_incr),
    .bool_range    (bool_range),
    .cur_range     (range),
    .low           (low),
    .cnt           (cnt),
    .word_1        (word_1),
    .word_2        (word_2),
    .emit_flag     (emit_flag),
    .result_valid  (result_valid)
  );

endmodule

/* testbench/tb_ref_model.sv */
`include "ec_defines.svh"

package tb_ref_model;

  localparam longint range_mask = (longint'(1) << `EC_RANGE_WIDTH) - 1;
  localparam longint low_mask   = (longint'(1) << `EC_LOW_WIDTH) - 1;

  // Xorshift32 step
  function automatic logic [31:0] xorshift32(logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Top byte of the range times the shifted probability, halved
  function automatic longint scaled_point(longint r, longint f);
    longint prod;
    prod = (r >> (`EC_RANGE_WIDTH - 8)) * (f >> `EC_PROB_SHIFT);
    return (prod >> 1) & range_mask;
  endfunction

  function automatic longint leading_zeros(longint value);
    longint n;
    n = `EC_RANGE_WIDTH;
    for (int i = 0; i < `EC_RANGE_WIDTH; i++) begin
      if (((value >> i) & 1) != 0) begin
        n = `EC_RANGE_WIDTH - 1 - i;
      end
    end
    return n;
  endfunction

  // One coded symbol or bool applied to the coder state
  function automatic void code_step(
    input  logic   bool_mode,
    input  longint fl,
    input  longint fh,
    input  longint symbol,
    input  longint nsyms,
    inout  longint rng,
    inout  longint low,
    inout  longint cnt,
    inout  longint word_1,
    inout  longint word_2,
    inout  longint emit_flag
  );
    longint u;
    longint v;
    longint incr;
    longint new_range;
    longint d;
    longint work;
    longint s_sum;
    longint c;
    longint first;
    longint last;
    if (bool_mode) begin
      v = (scaled_point(rng, fh) + `EC_MIN_PROB) & range_mask;
      if ((symbol & 1) != 0) begin
        incr      = (rng - v) & range_mask;
        new_range = v;
      end else begin
        incr      = 0;
        new_range = (rng - v) & range_mask;
      end
    end else begin
      if (symbol == 0) begin
        u = rng;
      end else begin
        u = (scaled_point(rng, fl) + `EC_MIN_PROB * (nsyms - symbol)) & range_mask;
      end
      v         = (scaled_point(rng, fh) + `EC_MIN_PROB * (nsyms - symbol - 1)) & range_mask;
      incr      = (rng - u) & range_mask;
      new_range = (u - v) & range_mask;
    end
    d     = leading_zeros(new_range);
    work  = low + incr;
    s_sum = cnt + d;
    first = 0;
    cnt   = s_sum;
    if (s_sum >= 0) begin
      c = cnt - d + `EC_RANGE_WIDTH;
      if (s_sum >= 8) begin
        first = (work >> c) & range_mask;
        work  = work & ((longint'(1) << c) - 1);
        c     = c - 8;
      end
      // Word keeps the carry above its byte
      last = (work >> c) & range_mask;
      work = work & ((longint'(1) << c) - 1);
      cnt  = c + d - 24;
      if (s_sum >= 8) begin
        word_1    = first;
        word_2    = last;
        emit_flag = 3;
      end else begin
        word_1    = last;
        emit_flag = 1;
      end
    end
    rng = (new_range << d) & range_mask;
    low = (work << d) & low_mask;
  endfunction

endpackage

/* testbench/tb_range_encoder.sv */
`timescale 1ns/1ns
`include "ec_defines.svh"

module tb_range_encoder;

  localparam int          num_tests       = 64;
  localparam int          reset_cycles    = 10;
  localparam int          watchdog_margin = 40;
  localparam int          max_latency     = 8;
  localparam int          watchdog_cycles = num_tests * 4 + reset_cycles + watchdog_margin;
  localparam logic [31:0] seed            = 32'h29eaa3cd;

  logic               general_clk;
  logic               reset;
  logic               symbol_strobe;
  logic               bool_mode;
  ec_pkg::range_t     fl;
  ec_pkg::range_t     fh;
  ec_pkg::symbol_t    symbol;
  ec_pkg::nsyms_t     nsyms;
  ec_pkg::range_t     range;
  ec_pkg::low_t       low;
  ec_pkg::cnt_t       cnt;
  ec_pkg::range_t     word_1;
  ec_pkg::range_t     word_2;
  ec_pkg::emit_flag_t emit_flag;
  logic               result_valid;

  // Stimulus table and expected coder state after each entry
  logic   mode_tab [num_tests];
  longint fl_tab   [num_tests];
  longint fh_tab   [num_tests];
  longint sym_tab  [num_tests];
  longint nsym_tab [num_tests];
  longint exp_tab  [num_tests][6];

  int          error_count;
  int          failed_tests;
  logic [31:0] rnd_state;

  range_encoder_top i_range_encoder_top (
    .general_clk   (general_clk),
    .reset         (reset),
    .symbol_strobe (symbol_strobe),
    .bool_mode     (bool_mode),
    .fl            (fl),
    .fh            (fh),
    .symbol        (symbol),
    .nsyms         (nsyms),
    .range         (range),
    .low           (low),
    .cnt           (cnt),
    .word_1        (word_1),
    .word_2        (word_2),
    .emit_flag     (emit_flag),
    .result_valid  (result_valid)
  );

  initial begin
    general_clk = 1'b0;
    forever #4 general_clk = ~general_clk;
  end

  // Watchdog
  initial begin
    #(watchdog_cycles * 8);
    $display("Timeout: the run did not finish within %0d clock cycles", watchdog_cycles);
    $display("ERRORS FOUND");
    $finish;
  end

  task automatic check_value(input string name, input longint expected, input longint actual);
    if (expected != actual) begin
      $display("ERR %s expected %0d actual %0d", name, expected, actual);
      error_count++;
    end
  endtask

  task automatic draw(input longint limit, output longint value);
    rnd_state = tb_ref_model::xorshift32(rnd_state);
    value     = longint'(rnd_state) % limit;
  endtask

  task automatic set_inputs(input int i, input logic m, input longint f_lo, input longint f_hi,
                            input longint s, input longint n);
    mode_tab[i] = m;
    fl_tab[i]   = f_lo;
    fh_tab[i]   = f_hi;
    sym_tab[i]  = s;
    nsym_tab[i] = n;
  endtask

  // ------------------------------------------------------------------
  // Table build with the reference model
  // ------------------------------------------------------------------
  task automatic build_table();
    longint st [6];
    longint a;
    longint b;
    longint n;
    longint s;
    longint pick;
    int     one_word;
    int     two_words;
    st        = '{longint'(`EC_RANGE_INIT), 0, longint'(`EC_CNT_INIT), 0, 0, 0};
    one_word  = 0;
    two_words = 0;
    for (int i = 0; i < num_tests; i++) begin
      draw(4, pick);
      draw(30001, a);
      draw(30001, b);
      draw(15, n);
      n = n + 2;
      draw(n, s);
      if (i == 0) set_inputs(i, 1'b0, 32768, 24000, 0, 4);
      else if (i == 1) set_inputs(i, 1'b0, 6000, 0, 3, 4);
      else if (i == 2) set_inputs(i, 1'b1, 0, 16384, 1, 2);
      else if (i == 3) set_inputs(i, 1'b1, 0, 16384, 0, 2);
      // Low-probability run where the range falls to 4 every time
      else if (i < 12) set_inputs(i, 1'b0, 0, 0, 15, 16);
      else if (i < 16) set_inputs(i, 1'b0, 20000, 20000, 7, 16);
      else if (pick == 0) set_inputs(i, 1'b1, 0, a, b & 1, 2);
      else set_inputs(i, 1'b0, (s == 0) ? 32768 : ((a > b) ? a : b),
                      (s == n - 1) ? 0 : ((a > b) ? b : a), s, n);
      tb_ref_model::code_step(mode_tab[i], fl_tab[i], fh_tab[i], sym_tab[i], nsym_tab[i],
                              st[0], st[1], st[2], st[3], st[4], st[5]);
      exp_tab[i] = st;
      if (st[5] == 1) one_word++;
      if (st[5] == 3) two_words++;
    end
    if (one_word == 0 || two_words == 0) begin
      $display("Stimulus table misses one-word or two-word emission");
      error_count++;
    end
  endtask

  task automatic check_state(input string name, input longint exp_state [6]);
    check_value({name, " range"}, exp_state[0], longint'(range));
    check_value({name, " low"}, exp_state[1], longint'(low));
    check_value({name, " cnt"}, exp_state[2], longint'(cnt));
    check_value({name, " word_1"}, exp_state[3], longint'(word_1));
    check_value({name, " word_2"}, exp_state[4], longint'(word_2));
    check_value({name, " emit_flag"}, exp_state[5], longint'(emit_flag));
  endtask

  // ------------------------------------------------------------------
  // Apply loop
  // ------------------------------------------------------------------
  initial begin
    string  name;
    int     cycles;
    int     errors_before;
    longint reset_state [6];
    reset         = 1'b1;
    symbol_strobe = 1'b0;
    bool_mode     = 1'b0;
    fl            = '0;
    fh            = '0;
    symbol        = '0;
    nsyms         = '0;
    error_count   = 0;
    failed_tests  = 0;
    rnd_state     = seed;
    reset_state   = '{longint'(`EC_RANGE_INIT), 0, longint'(`EC_CNT_INIT), 0, 0, 0};
    build_table();
    repeat (reset_cycles) @(negedge general_clk);
    reset = 1'b0;

    errors_before = error_count;
    check_state("reset", reset_state);
    check_value("reset result_valid", 0, longint'(result_valid));
    $display("reset %s", (error_count == errors_before) ? "pass" : "fail");
    if (error_count != errors_before) failed_tests++;

    for (int i = 0; i < num_tests; i++) begin
      name          = $sformatf("t%0d_%s", i, mode_tab[i] ? "bool" : "cdf");
      errors_before = error_count;
      bool_mode     = mode_tab[i];
      fl            = ec_pkg::range_t'(fl_tab[i]);
      fh            = ec_pkg::range_t'(fh_tab[i]);
      symbol        = ec_pkg::symbol_t'(sym_tab[i]);
      nsyms         = ec_pkg::nsyms_t'(nsym_tab[i]);
      symbol_strobe = 1'b1;
      @(negedge general_clk);
      symbol_strobe = 1'b0;
      cycles        = 1;
      while (!result_valid && cycles < max_latency) begin
        @(negedge general_clk);
        cycles++;
      end
      if (!result_valid) begin
        $display("%s: result_valid did not rise within %0d cycles", name, max_latency);
        error_count++;
      end else begin
        check_value({name, " latency"}, 2, longint'(cycles));
        check_state(name, exp_tab[i]);
      end
      // Result is a single-cycle pulse
      @(negedge general_clk);
      check_value({name, " valid pulse"}, 0, longint'(result_valid));
      $display("%s %s", name, (error_count == errors_before) ? "pass" : "fail");
      if (error_count != errors_before) failed_tests++;
    end

    $display("tests: %0d, failed: %0d, errors: %0d", num_tests + 1, failed_tests, error_count);
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* compile.f */
+incdir+include
src/ec_pkg.sv
src/cdf_interval.sv
src/bool_interval.sv
src/renormalizer.sv
src/range_encoder_top.sv
testbench/tb_ref_model.sv
testbench/tb_range_encoder.sv

/* run_sim.sh */
#!/bin/sh
# Builds the range encoder testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  --top-module tb_range_encoder \
  -f compile.f \
  -o sim_range_encoder

./obj_dir/sim_range_encoder > sim.log 2>&1 || true
cat sim.log

if grep -q "^NO ERRORS$" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
